//--- list.f
csr_pkg.sv
csr_decode.sv
csr_counters.sv
csr_file.sv
csr_unit.sv
tb_csr_checker.sv
tb_csr_unit.sv

//--- run_sim.sh
#!/usr/bin/env bash
# builds the CSR unit testbench with Verilator, runs it and checks the log.
set -u

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f list.f --top-module tb_csr_unit \
  -Mdir obj_dir -o tb_csr_unit_sim > build.log 2>&1
if [ $? -ne 0 ]; then
  echo "build failed, see build.log"
  exit 1
fi

./obj_dir/tb_csr_unit_sim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -q "Simulation finished: FAIL" sim.log; then
  exit 1
fi

if ! grep -q "Simulation finished: PASS" sim.log; then
  echo "no result line in sim.log"
  exit 1
fi

exit 0

//--- tb_csr_unit.sv
// testbench top for the CSR unit that drives random SYSTEM words and models the expected responses.
`timescale 1ns/1ps
`default_nettype none

module tb_csr_unit;

  localparam int          TIME_DIV  = 4;
  localparam logic [31:0] HART_ID   = 32'h0000_0003;
  localparam int          MAX_WAIT  = 200;
  localparam logic [11:0] RW_ADDRS [8] = '{12'h300, 12'h304, 12'h305, 12'h340,
                                           12'h341, 12'h342, 12'h343, 12'h344};
  localparam logic [11:0] RO_ADDRS [15] = '{12'hB00, 12'hB02, 12'hB80, 12'hB82, 12'hC00,
                                            12'hC01, 12'hC02, 12'hC80, 12'hC81, 12'hC82,
                                            12'h301, 12'hF11, 12'hF12, 12'hF13, 12'hF14};

  typedef struct packed {
    logic [31:0] rd_data;
    logic [4:0]  rd_addr;
    logic        we;
    logic        illegal;
  } s_obs_t;

  logic        clk;
  logic        rst_i;
  logic        valid_i;
  logic [31:0] instr_i;
  logic [31:0] rs1_data_i;
  logic        stall_i;
  logic        retire_i;
  logic [31:0] rd_data_o;
  logic [4:0]  rd_addr_o;
  logic        rd_we_o;
  logic        illegal_o;
  logic        chk_en;
  s_obs_t      exp_obs;
  int          checks;
  int          errors;
  int          cycles_run;
  logic        timed_out;
  logic [31:0] rng;

  // reference model state.
  logic [31:0] m_csr [8];
  logic [63:0] m_cycle;
  logic [63:0] m_time;
  logic [63:0] m_instret;
  int          m_presc;
  logic        m_commit;
  int          m_idx;
  logic [31:0] m_new;

  csr_unit #(
    .TIME_DIV (TIME_DIV),
    .HART_ID  (HART_ID)
  ) u_csr_unit (
    .clk        (clk),
    .rst_i      (rst_i),
    .valid_i    (valid_i),
    .instr_i    (instr_i),
    .rs1_data_i (rs1_data_i),
    .stall_i    (stall_i),
    .retire_i   (retire_i),
    .rd_data_o  (rd_data_o),
    .rd_addr_o  (rd_addr_o),
    .rd_we_o    (rd_we_o),
    .illegal_o  (illegal_o)
  );

  tb_csr_checker u_checker (
    .clk       (clk),
    .en_i      (chk_en),
    .rd_data_i (rd_data_o),
    .rd_addr_i (rd_addr_o),
    .rd_we_i   (rd_we_o),
    .illegal_i (illegal_o),
    .exp_i     (exp_obs),
    .checks_o  (checks),
    .errors_o  (errors)
  );

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  initial begin
    #(40 * 20000);
    $display("timeout: simulation ran past its cycle limit");
    $display("Simulation finished: FAIL");
    $finish;
  end

  function automatic logic [31:0] draw_random();
    rng = rng ^ (rng << 13);
    rng = rng ^ (rng >> 17);
    rng = rng ^ (rng << 5);
    return rng;
  endfunction

  function automatic int rw_index(input logic [11:0] a);
    for (int i = 0; i < 8; i++) begin
      if (RW_ADDRS[i] == a) return i;
    end
    return -1;
  endfunction

  function automatic logic [31:0] wmask_of(input int idx);
    case (idx)
      0:       return 32'h0000_0088; // mstatus bits 3 and 7.
      1:       return 32'h0000_0888; // mie bits 3, 7 and 11.
      2:       return 32'hFFFF_FFFC;
      4:       return 32'hFFFF_FFFE;
      7:       return 32'h0000_0888;
      default: return 32'hFFFF_FFFF;
    endcase
  endfunction

  // returns 1 and the value when the address is a read-only CSR.
  function automatic logic read_ro(input logic [11:0] a, output logic [31:0] v);
    v = 32'd0;
    case (a)
      12'hB00, 12'hC00: v = m_cycle[31:0];
      12'hB80, 12'hC80: v = m_cycle[63:32];
      12'hB02, 12'hC02: v = m_instret[31:0];
      12'hB82, 12'hC82: v = m_instret[63:32];
      12'hC01:          v = m_time[31:0];
      12'hC81:          v = m_time[63:32];
      12'h301:          v = csr_pkg::M_ISA_ID;
      12'hF11:          v = csr_pkg::M_VENDOR_ID;
      12'hF12:          v = csr_pkg::M_ARCH_ID;
      12'hF13:          v = csr_pkg::M_IMPL_ID;
      12'hF14:          v = HART_ID;
      default:          return 1'b0;
    endcase
    return 1'b1;
  endfunction

  function automatic logic [2:0] draw_op();
    logic [2:0] codes [6];

    codes = '{3'd1, 3'd2, 3'd3, 3'd5, 3'd6, 3'd7};
    return codes[draw_random() % 6];
  endfunction

  // ##########################################################################
  // reference model
  // ##########################################################################
  task automatic set_expect(input logic [31:0] ins, input logic [31:0] rs1,
                            input logic vld, input logic stl);
    logic [2:0]  f3;
    logic [4:0]  src;
    logic [31:0] old;
    logic [31:0] opnd;
    logic [31:0] comb;
    logic [31:0] msk;
    logic        known;
    logic        mal;
    logic        wr;
    int          idx;

    f3 = ins[14:12];
    src = ins[19:15];
    idx = rw_index(ins[31:20]);
    known = read_ro(ins[31:20], old);
    if (idx >= 0) begin
      old = m_csr[idx];
      known = 1'b1;
    end
    mal = (ins[6:0] != 7'h73) || (f3 == 3'd0) || (f3 == 3'd4);
    wr = vld && !mal && ((f3 == 3'd1) || (f3 == 3'd5) || (src != 5'd0));
    exp_obs.illegal = vld && (mal || !known || (wr && idx < 0));
    exp_obs.rd_data = old;
    exp_obs.rd_addr = ins[11:7];
    exp_obs.we = vld && !exp_obs.illegal && !stl && (ins[11:7] != 5'd0);
    opnd = f3[2] ? {27'd0, src} : rs1;
    case (f3[1:0])
      2'd1:    comb = opnd;
      2'd2:    comb = old | opnd;
      default: comb = old & ~opnd;
    endcase
    msk = wmask_of(idx);
    m_commit = wr && !exp_obs.illegal && !stl;
    m_idx = idx;
    m_new = (old & ~msk) | (comb & msk);
  endtask

  task automatic step_model(input logic ret);
    if (m_commit) m_csr[m_idx] = m_new;
    m_cycle = m_cycle + 64'd1;
    if (ret) m_instret = m_instret + 64'd1;
    if (m_presc == TIME_DIV - 1) begin
      m_presc = 0;
      m_time = m_time + 64'd1;
    end else begin
      m_presc = m_presc + 1;
    end
  endtask

  task automatic apply_reset();
    chk_en = 1'b0;
    valid_i = 1'b0;
    stall_i = 1'b0;
    retire_i = 1'b0;
    rst_i = 1'b1;
    repeat (16) @(posedge clk);
    @(negedge clk);
    rst_i = 1'b0;
    for (int i = 0; i < 8; i++) m_csr[i] = 32'd0;
    m_cycle = 64'd0;
    m_time = 64'd0;
    m_instret = 64'd0;
    m_presc = 0;
    m_commit = 1'b0;
  endtask

  task automatic run_cycle(input logic [31:0] ins, input logic [31:0] rs1,
                           input logic vld, input logic stl, input logic ret);
    instr_i = ins;
    rs1_data_i = rs1;
    valid_i = vld;
    stall_i = stl;
    retire_i = ret;
    set_expect(ins, rs1, vld, stl);
    chk_en = 1'b1;
    cycles_run++;
    @(posedge clk);
    step_model(ret);
    @(negedge clk);
  endtask

  task automatic wait_checks(input int target);
    for (int i = 0; i < MAX_WAIT && checks < target; i++) @(posedge clk);
    if (checks < target) begin
      $display("timeout: checker saw %0d of %0d cycles", checks, target);
      timed_out = 1'b1;
    end
  endtask

  // ##########################################################################
  // tests
  // ##########################################################################
  task automatic run_test(input int kind, input string name, input int n);
    logic [11:0] a;
    logic [4:0]  src;
    logic [2:0]  f3;
    logic [6:0]  opc;
    logic [31:0] r;
    logic        vld;
    logic        stl;
    int          err0;
    int          base;

    err0 = errors;
    if (kind == 5) apply_reset();
    base = cycles_run;
    for (int i = 0; i < n; i++) begin
      r = draw_random();
      a = RW_ADDRS[r[2:0]];
      f3 = draw_op();
      src = r[8:4];
      opc = 7'h73;
      vld = (r[11:9] != 3'd0);
      stl = (kind == 3);
      case (kind)
        1: begin
          a = (r[12]) ? RO_ADDRS[r[19:16] % 15] : RW_ADDRS[r[2:0]];
          f3 = {r[13], 1'b1, r[14]};
          src = 5'd0;
        end
        2: begin
          case (r[21:20])
            2'd0:    f3 = {r[13], 2'b00};
            2'd1:    opc = 7'h33;
            2'd2:    a = r[31:20];
            default: a = RO_ADDRS[r[19:16] % 15];
          endcase
        end
        4, 5: begin
          a = (kind == 5 && i < 8) ? RW_ADDRS[i] : RO_ADDRS[r[19:16] % 15];
          f3 = 3'd2;
          src = 5'd0;
          vld = 1'b1;
        end
        default: ;
      endcase
      run_cycle({a, src, f3, r[26:22], opc}, draw_random(), vld, stl, r[30]);
    end
    wait_checks(base + n);
    $display("test %s: %0d cycles, %0d errors", name, n, errors - err0);
  endtask

  initial begin
    rng = 32'heec3_7235;
    timed_out = 1'b0;
    cycles_run = 0;
    instr_i = 32'd0;
    rs1_data_i = 32'd0;
    exp_obs = '0;
    apply_reset();
    run_test(0, "read_write_ops", 400);
    run_test(1, "zero_source", 200);
    run_test(2, "illegal_requests", 300);
    run_test(3, "stall", 200);
    run_test(4, "counters_and_ids", 300);
    run_test(5, "reset_values", 40);
    chk_en = 1'b0;
    $display("checks %0d, errors %0d", checks, errors);
    if (errors == 0 && !timed_out) begin
      $display("Simulation finished: PASS");
    end else begin
      $display("Simulation finished: FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- tb_csr_checker.sv
// testbench checker, compares the CSR unit outputs with the model at each rising clock edge.
`timescale 1ns/1ps
`default_nettype none

module tb_csr_checker (
  input  wire        clk,
  input  wire        en_i,
  input  wire [31:0] rd_data_i,
  input  wire [4:0]  rd_addr_i,
  input  wire        rd_we_i,
  input  wire        illegal_i,
  input  wire [38:0] exp_i,
  output int         checks_o,
  output int         errors_o
);

  typedef struct packed {
    logic [31:0] rd_data;
    logic [4:0]  rd_addr;
    logic        we;
    logic        illegal;
  } s_obs_t;

  s_obs_t exp;
  int     checks = 0;
  int     errors = 0;

  assign exp = exp_i;
  assign checks_o = checks;
  assign errors_o = errors;

  always @(posedge clk) begin : compare
    int n;

    n = 0;
    if (en_i) begin
      if (rd_data_i !== exp.rd_data) begin
        $display("ERR rd_data_o got %08h exp %08h", rd_data_i, exp.rd_data);
        n++;
      end
      if (rd_addr_i !== exp.rd_addr) begin
        $display("ERR rd_addr_o got %02h exp %02h", rd_addr_i, exp.rd_addr);
        n++;
      end
      if (rd_we_i !== exp.we) begin
        $display("ERR rd_we_o got %01h exp %01h", rd_we_i, exp.we);
        n++;
      end
      if (illegal_i !== exp.illegal) begin
        $display("ERR illegal_o got %01h exp %01h", illegal_i, exp.illegal);
        n++;
      end
      checks = checks + 1;
      errors = errors + n;
    end
  end : compare

endmodule

`default_nettype wire

//--- csr_unit.sv
// top level of the machine CSR unit, decodes one SYSTEM word per cycle and accesses the CSRs.
`timescale 1ns/1ps
`default_nettype none

module csr_unit #(
  parameter int              TIME_DIV = 4,
  parameter csr_pkg::rdata_t HART_ID  = csr_pkg::M_HART_ID
) (
  input  wire                  clk,
  input  wire                  rst_i,
  input  wire                  valid_i,
  input  wire csr_pkg::rdata_t instr_i,
  input  wire csr_pkg::rdata_t rs1_data_i,
  input  wire                  stall_i,
  input  wire                  retire_i,
  output csr_pkg::rdata_t      rd_data_o,
  output logic [4:0]           rd_addr_o,
  output logic                 rd_we_o,
  output logic                 illegal_o
);

  csr_pkg::s_csr_t csr_req;

  // ##########################################################################
  // decode and CSR access
  // ##########################################################################
  csr_decode u_csr_decode (
    .instr_i (instr_i),
    .req_o   (csr_req)
  );

  csr_file #(
    .TIME_DIV (TIME_DIV),
    .HART_ID  (HART_ID)
  ) u_csr_file (
    .clk        (clk),
    .rst_i      (rst_i),
    .valid_i    (valid_i),
    .stall_i    (stall_i),
    .req_i      (csr_req),
    .rs1_data_i (rs1_data_i),
    .retire_i   (retire_i),
    .rd_data_o  (rd_data_o),
    .rd_addr_o  (rd_addr_o),
    .rd_we_o    (rd_we_o),
    .illegal_o  (illegal_o)
  );

endmodule

`default_nettype wire

//--- csr_file.sv
// machine CSR registers with read mux, masked writes and legality check, fed by the decoder.
`timescale 1ns/1ps
`default_nettype none

module csr_file #(
  parameter int              TIME_DIV = 4,
  parameter csr_pkg::rdata_t HART_ID  = csr_pkg::M_HART_ID
) (
  input  wire                   clk,
  input  wire                   rst_i,
  input  wire                   valid_i,
  input  wire                   stall_i,
  input  wire csr_pkg::s_csr_t  req_i,
  input  wire csr_pkg::rdata_t  rs1_data_i,
  input  wire                   retire_i,
  output csr_pkg::rdata_t       rd_data_o,
  output logic [4:0]            rd_addr_o,
  output logic                  rd_we_o,
  output logic                  illegal_o
);

  typedef struct packed {
    csr_pkg::rdata_t mstatus;
    csr_pkg::rdata_t mie;
    csr_pkg::rdata_t mtvec;
    csr_pkg::rdata_t mscratch;
    csr_pkg::rdata_t mepc;
    csr_pkg::rdata_t mcause;
    csr_pkg::rdata_t mtval;
    csr_pkg::rdata_t mip;
  } s_mcsr_t;

  s_mcsr_t             mcsr_ff;
  s_mcsr_t             next_mcsr;
  csr_pkg::rdata_ext_t cnt_cycle;
  csr_pkg::rdata_ext_t cnt_time;
  csr_pkg::rdata_ext_t cnt_instret;
  csr_pkg::rdata_t     rd_data;
  csr_pkg::rdata_t     wmask;
  csr_pkg::rdata_t     new_val;
  csr_pkg::s_csr_wr_t  wr_arg;
  logic                known_addr;
  logic                read_only;
  logic                wr_attempt;
  logic                illegal;
  logic                commit;

  function automatic csr_pkg::rdata_t wr_csr_val(csr_pkg::s_csr_wr_t arg);
    csr_pkg::rdata_t comb;

    case (arg.op)
      csr_pkg::RV_CSR_RW,
      csr_pkg::RV_CSR_RWI: comb = arg.operand;
      csr_pkg::RV_CSR_RS,
      csr_pkg::RV_CSR_RSI: comb = arg.old | arg.operand;
      csr_pkg::RV_CSR_RC,
      csr_pkg::RV_CSR_RCI: comb = arg.old & ~arg.operand;
      default:             comb = arg.old;
    endcase
    return (arg.old & ~arg.mask) | (comb & arg.mask); // bits outside the mask stay.
  endfunction

  csr_counters #(
    .TIME_DIV (TIME_DIV)
  ) u_csr_counters (
    .clk       (clk),
    .rst_i     (rst_i),
    .retire_i  (retire_i),
    .cycle_o   (cnt_cycle),
    .time_o    (cnt_time),
    .instret_o (cnt_instret)
  );

  // ##########################################################################
  // read mux and address classification
  // ##########################################################################
  always_comb begin : rd_csr
    rd_data    = '0;
    wmask      = '0;
    known_addr = 1'b1;
    read_only  = 1'b1;
    case (req_i.addr)
      csr_pkg::RV_CSR_MSTATUS: begin
        rd_data   = mcsr_ff.mstatus;
        wmask     = csr_pkg::MSTATUS_WMASK;
        read_only = 1'b0;
      end
      csr_pkg::RV_CSR_MIE: begin
        rd_data   = mcsr_ff.mie;
        wmask     = csr_pkg::MIE_WMASK;
        read_only = 1'b0;
      end
      csr_pkg::RV_CSR_MTVEC: begin
        rd_data   = mcsr_ff.mtvec;
        wmask     = csr_pkg::MTVEC_WMASK;
        read_only = 1'b0;
      end
      csr_pkg::RV_CSR_MSCRATCH: begin
        rd_data   = mcsr_ff.mscratch;
        wmask     = '1;
        read_only = 1'b0;
      end
      csr_pkg::RV_CSR_MEPC: begin
        rd_data   = mcsr_ff.mepc;
        wmask     = csr_pkg::MEPC_WMASK;
        read_only = 1'b0;
      end
      csr_pkg::RV_CSR_MCAUSE: begin
        rd_data   = mcsr_ff.mcause;
        wmask     = '1;
        read_only = 1'b0;
      end
      csr_pkg::RV_CSR_MTVAL: begin
        rd_data   = mcsr_ff.mtval;
        wmask     = '1;
        read_only = 1'b0;
      end
      csr_pkg::RV_CSR_MIP: begin
        rd_data   = mcsr_ff.mip;
        wmask     = csr_pkg::MIP_WMASK;
        read_only = 1'b0;
      end
      csr_pkg::RV_CSR_MCYCLE,
      csr_pkg::RV_CSR_CYCLE:     rd_data = cnt_cycle[31:0];
      csr_pkg::RV_CSR_MCYCLEH,
      csr_pkg::RV_CSR_CYCLEH:    rd_data = cnt_cycle[63:32];
      csr_pkg::RV_CSR_MINSTRET,
      csr_pkg::RV_CSR_INSTRET:   rd_data = cnt_instret[31:0];
      csr_pkg::RV_CSR_MINSTRETH,
      csr_pkg::RV_CSR_INSTRETH:  rd_data = cnt_instret[63:32];
      csr_pkg::RV_CSR_TIME:      rd_data = cnt_time[31:0];
      csr_pkg::RV_CSR_TIMEH:     rd_data = cnt_time[63:32];
      csr_pkg::RV_CSR_MISA:      rd_data = csr_pkg::M_ISA_ID;
      csr_pkg::RV_CSR_MVENDORID: rd_data = csr_pkg::M_VENDOR_ID;
      csr_pkg::RV_CSR_MARCHID:   rd_data = csr_pkg::M_ARCH_ID;
      csr_pkg::RV_CSR_MIMPLID:   rd_data = csr_pkg::M_IMPL_ID;
      csr_pkg::RV_CSR_MHARTID:   rd_data = HART_ID;
      default:                   known_addr = 1'b0;
    endcase
  end : rd_csr

  // set and clear with a zero source only read.
  assign wr_attempt = valid_i & ~req_i.malformed &
                      ((req_i.op == csr_pkg::RV_CSR_RW) | (req_i.op == csr_pkg::RV_CSR_RWI) |
                       (req_i.src != 5'd0));
  assign illegal = valid_i & (req_i.malformed | ~known_addr | (wr_attempt & read_only));
  assign commit  = wr_attempt & ~illegal & ~stall_i;

  always_comb begin
    wr_arg.op      = req_i.op;
    wr_arg.operand = req_i.use_imm ? {27'd0, req_i.src} : rs1_data_i; // zimm zero-extended.
    wr_arg.old     = rd_data;
    wr_arg.mask    = wmask;
  end

  assign new_val = wr_csr_val(wr_arg);

  always_comb begin : wr_csr
    next_mcsr = mcsr_ff;
    if (commit) begin
      case (req_i.addr)
        csr_pkg::RV_CSR_MSTATUS:  next_mcsr.mstatus  = new_val;
        csr_pkg::RV_CSR_MIE:      next_mcsr.mie      = new_val;
        csr_pkg::RV_CSR_MTVEC:    next_mcsr.mtvec    = new_val;
        csr_pkg::RV_CSR_MSCRATCH: next_mcsr.mscratch = new_val;
        csr_pkg::RV_CSR_MEPC:     next_mcsr.mepc     = new_val;
        csr_pkg::RV_CSR_MCAUSE:   next_mcsr.mcause   = new_val;
        csr_pkg::RV_CSR_MTVAL:    next_mcsr.mtval    = new_val;
        csr_pkg::RV_CSR_MIP:      next_mcsr.mip      = new_val;
        default:                  next_mcsr = mcsr_ff;
      endcase
    end
  end : wr_csr

  always_ff @(posedge clk) begin
    if (rst_i) begin
      mcsr_ff <= '0;
    end else begin
      mcsr_ff <= next_mcsr;
    end
  end

  assign rd_data_o = rd_data;           // old value, before this cycle's write.
  assign rd_addr_o = req_i.rd;
  assign illegal_o = illegal;
  assign rd_we_o   = valid_i & ~illegal & ~stall_i & (req_i.rd != 5'd0);

  // ##########################################################################
  // checks
  // ##########################################################################
  a_no_illegal_wb: assert property (
    @(posedge clk) disable iff (rst_i) !(illegal_o && rd_we_o)
  ) else $error("writeback enabled on an illegal CSR request.");

  a_stall_holds: assert property (
    @(posedge clk) disable iff (rst_i) stall_i |=> $stable(mcsr_ff)
  ) else $error("machine CSR changed under stall.");

endmodule

`default_nettype wire

//--- csr_counters.sv
// 64-bit cycle, time and instret counters with a time prescaler, read by the CSR file.
`timescale 1ns/1ps
`default_nettype none

module csr_counters #(
  parameter int TIME_DIV = 4
) (
  input  wire                  clk,
  input  wire                  rst_i,
  input  wire                  retire_i,
  output csr_pkg::rdata_ext_t  cycle_o,
  output csr_pkg::rdata_ext_t  time_o,
  output csr_pkg::rdata_ext_t  instret_o
);

  localparam int PW = (TIME_DIV > 1) ? $clog2(TIME_DIV) : 1;
  localparam logic [PW-1:0] PRESC_LAST = PW'(TIME_DIV - 1);

  logic [PW-1:0]       presc_ff;
  logic                time_tick;
  csr_pkg::rdata_ext_t cycle_ff;
  csr_pkg::rdata_ext_t time_ff;
  csr_pkg::rdata_ext_t instret_ff;

  assign time_tick = (presc_ff == PRESC_LAST); // always true when TIME_DIV is 1.

  always_ff @(posedge clk) begin
    if (rst_i) begin
      presc_ff   <= '0;
      cycle_ff   <= '0;
      time_ff    <= '0;
      instret_ff <= '0;
    end else begin
      cycle_ff <= cycle_ff + 64'd1;
      presc_ff <= time_tick ? '0 : presc_ff + 1'b1;
      if (time_tick) begin
        time_ff <= time_ff + 64'd1;
      end
      if (retire_i) begin
        instret_ff <= instret_ff + 64'd1;
      end
    end
  end

  assign cycle_o   = cycle_ff;
  assign time_o    = time_ff;
  assign instret_o = instret_ff;

  // ##########################################################################
  // checks
  // ##########################################################################
  // retirement can never run ahead of the clock.
  a_instret_le_cycle: assert property (
    @(posedge clk) disable iff (rst_i) instret_ff <= cycle_ff + 64'd1
  ) else $error("instret ran ahead of cycle.");

endmodule

`default_nettype wire

//--- csr_decode.sv
// decoder for SYSTEM instruction words, produces the CSR request seen by the CSR file.
`timescale 1ns/1ps
`default_nettype none

module csr_decode (
  input  wire csr_pkg::rdata_t instr_i,
  output csr_pkg::s_csr_t      req_o
);

  logic [6:0] opcode;
  logic [2:0] funct3;
  logic       bad_opcode;
  logic       bad_funct3;

  // ##########################################################################
  // field slicing
  // ##########################################################################
  assign opcode = instr_i[6:0];
  assign funct3 = instr_i[14:12];

  assign bad_opcode = (opcode != csr_pkg::RV_OPC_SYSTEM);
  assign bad_funct3 = (funct3[1:0] == 2'b00); // ecall/ebreak space and 3'b100.

  always_comb begin
    req_o.op        = csr_pkg::csr_op_t'(funct3);
    req_o.addr      = instr_i[31:20];
    req_o.rd        = instr_i[11:7];
    req_o.src       = instr_i[19:15];
    req_o.use_imm   = funct3[2];     // immediate forms carry zimm in rs1.
    req_o.malformed = bad_opcode | bad_funct3;
  end

endmodule

`default_nettype wire

//--- csr_pkg.sv
// machine-mode CSR types, addresses, ID values and write masks shared by the CSR unit.
`default_nettype none

package csr_pkg;

  typedef logic [31:0] rdata_t;
  typedef logic [63:0] rdata_ext_t;
  typedef logic [11:0] csr_addr_t;

  localparam logic [6:0] RV_OPC_SYSTEM = 7'b111_0011;

  // ##########################################################################
  // funct3 codes, 3'b000 and 3'b100 are not CSR operations
  // ##########################################################################
  typedef enum logic [2:0] {
    RV_CSR_RW  = 3'b001,
    RV_CSR_RS  = 3'b010,
    RV_CSR_RC  = 3'b011,
    RV_CSR_RWI = 3'b101,
    RV_CSR_RSI = 3'b110,
    RV_CSR_RCI = 3'b111
  } csr_op_t;

  // ##########################################################################
  // CSR addresses
  // ##########################################################################
  localparam csr_addr_t RV_CSR_MSTATUS   = 12'h300;
  localparam csr_addr_t RV_CSR_MISA      = 12'h301;
  localparam csr_addr_t RV_CSR_MIE       = 12'h304;
  localparam csr_addr_t RV_CSR_MTVEC     = 12'h305;
  localparam csr_addr_t RV_CSR_MSCRATCH  = 12'h340;
  localparam csr_addr_t RV_CSR_MEPC      = 12'h341;
  localparam csr_addr_t RV_CSR_MCAUSE    = 12'h342;
  localparam csr_addr_t RV_CSR_MTVAL     = 12'h343;
  localparam csr_addr_t RV_CSR_MIP       = 12'h344;
  localparam csr_addr_t RV_CSR_MCYCLE    = 12'hB00;
  localparam csr_addr_t RV_CSR_MINSTRET  = 12'hB02;
  localparam csr_addr_t RV_CSR_MCYCLEH   = 12'hB80;
  localparam csr_addr_t RV_CSR_MINSTRETH = 12'hB82;
  localparam csr_addr_t RV_CSR_CYCLE     = 12'hC00;
  localparam csr_addr_t RV_CSR_TIME      = 12'hC01;
  localparam csr_addr_t RV_CSR_INSTRET   = 12'hC02;
  localparam csr_addr_t RV_CSR_CYCLEH    = 12'hC80;
  localparam csr_addr_t RV_CSR_TIMEH     = 12'hC81;
  localparam csr_addr_t RV_CSR_INSTRETH  = 12'hC82;
  localparam csr_addr_t RV_CSR_MVENDORID = 12'hF11;
  localparam csr_addr_t RV_CSR_MARCHID   = 12'hF12;
  localparam csr_addr_t RV_CSR_MIMPLID   = 12'hF13;
  localparam csr_addr_t RV_CSR_MHARTID   = 12'hF14;

  localparam rdata_t M_ISA_ID    = 32'h4000_0100; // mxl=1, base I.
  localparam rdata_t M_VENDOR_ID = 32'h0000_0000;
  localparam rdata_t M_ARCH_ID   = 32'h0000_0000;
  localparam rdata_t M_IMPL_ID   = 32'h0000_0001;
  localparam rdata_t M_HART_ID   = 32'h0000_0000;

  localparam rdata_t MSTATUS_WMASK = 32'h0000_0088; // mie and mpie.
  localparam rdata_t MIE_WMASK     = 32'h0000_0888; // software, timer, external.
  localparam rdata_t MIP_WMASK     = 32'h0000_0888;
  localparam rdata_t MTVEC_WMASK   = 32'hFFFF_FFFC; // direct mode only.
  localparam rdata_t MEPC_WMASK    = 32'hFFFF_FFFE;

  typedef struct packed {
    csr_op_t   op;
    csr_addr_t addr;
    logic [4:0] rd;
    logic [4:0] src;       // rs1 index or zimm.
    logic       use_imm;
    logic       malformed;
  } s_csr_t;

  typedef struct packed {
    csr_op_t op;
    rdata_t  operand;
    rdata_t  old;
    rdata_t  mask;
  } s_csr_wr_t;

endpackage

`default_nettype wire
